/* core_pkg.sv */
package core_pkg;

    // one instruction or one byte address
    typedef logic [31:0] word_t;

    // fetch data for one request
    // low word at the fetch pc, high word at pc + 4
    typedef logic [63:0] pair_t;

    // mips major opcode field, inst[31:26]
    typedef logic [5:0] opcode_t;

    // function field under SPECIAL, inst[5:0]
    typedef logic [5:0] funct_t;

    // branch class seen by the later stages
    typedef enum logic [1:0] {
        class_none,
        class_branch,
        class_jump,
        class_jump_reg
    } inst_class_e;

    localparam opcode_t OPC_SPECIAL = 6'b000000;
    localparam opcode_t OPC_J       = 6'b000010;
    localparam opcode_t OPC_JAL     = 6'b000011;
    localparam opcode_t OPC_BEQ     = 6'b000100;
    localparam opcode_t OPC_BNE     = 6'b000101;
    localparam opcode_t OPC_BLEZ    = 6'b000110;
    localparam opcode_t OPC_BGTZ    = 6'b000111;

    localparam funct_t FUNCT_JR   = 6'b001000;
    localparam funct_t FUNCT_JALR = 6'b001001;

    // one queue slot, 65 bits
    // exc entries carry a zero instruction
    typedef struct packed {
        word_t pc;
        word_t inst;
        logic  exc;
    } inst_entry_t;

endpackage

/* fetch_pair_if.sv */
interface fetch_pair_if #(
    parameter int QUEUE_DEPTH = 8
);

    // count wide enough to hold a full queue
    localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1;

    // one pair, or one exc entry when push_exc is set
    logic            push;
    core_pkg::word_t push_pc;
    core_pkg::pair_t push_data;
    logic            push_exc;

    // redirect, empties the queue on this edge
    logic            flush;

    // free entries, from the registered count
    logic [CNT_W-1:0] free_slots;

    modport source (
        output push, push_pc, push_data, push_exc, flush,
        input  free_slots
    );

    modport sink (
        input  push, push_pc, push_data, push_exc, flush,
        output free_slots
    );

endinterface

/* inst_slot_if.sv */
interface inst_slot_if;

    // oldest entry of the queue
    logic                  head_valid;
    core_pkg::inst_entry_t head;

    // consumer takes the head this cycle
    // only pulsed while head_valid is high
    logic                  pop;

    modport source (
        output head_valid, head,
        input  pop
    );

    modport sink (
        input  head_valid, head,
        output pop
    );

endinterface

/* pc_sequencer.sv */
module pc_sequencer #(
    parameter core_pkg::word_t RESET_PC = 32'hbfc0_0000,
    parameter int QUEUE_DEPTH = 8
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            i_redirect_valid,
    input  core_pkg::word_t i_redirect_pc,
    input  logic            i_iresp_addr_ok,
    input  core_pkg::pair_t i_iresp_data,
    output logic            o_ireq_valid,
    output core_pkg::word_t o_ireq_addr,
    fetch_pair_if.source    pair
);

    localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1;
    // pair in flight plus the next pair
    localparam logic [CNT_W-1:0] FREE_MARGIN = CNT_W'(4);

    core_pkg::word_t fetch_pc;
    core_pkg::word_t pend_pc;
    core_pkg::word_t rsp_pc;
    logic pend_valid;
    logic data_expected;
    logic drop;
    logic halted;
    logic started;
    logic req_hold;
    logic pc_aligned;
    logic accept;
    logic busy;
    logic data_push;
    logic exc_push;

    assign pc_aligned = fetch_pc[1:0] == 2'b00;

    // once raised, valid stays up until addr_ok
    // a new request needs an aligned pc and room for two pairs
    assign o_ireq_valid = req_hold
                        | (started & pc_aligned & (pair.free_slots >= FREE_MARGIN));
    assign o_ireq_addr  = fetch_pc;

    assign accept = o_ireq_valid & i_iresp_addr_ok;
    // address must hold, so a redirect here goes to pend_pc
    assign busy   = o_ireq_valid & ~i_iresp_addr_ok;

    // data shows up one cycle after accept
    // stale or redirect-cycle data never reaches the queue
    assign data_push = data_expected & ~drop & ~i_redirect_valid;

    // misaligned pc, one exc entry then stop
    assign exc_push = started & ~pc_aligned & ~halted & ~data_push
                    & ~i_redirect_valid & (pair.free_slots != '0);

    assign pair.push      = data_push | exc_push;
    assign pair.push_exc  = exc_push;
    assign pair.push_pc   = exc_push ? fetch_pc : rsp_pc;
    assign pair.push_data = i_iresp_data;
    assign pair.flush     = i_redirect_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc      <= RESET_PC;
            pend_valid    <= 1'b0;
            data_expected <= 1'b0;
            drop          <= 1'b0;
            halted        <= 1'b0;
            started       <= 1'b0;
            req_hold      <= 1'b0;
        end else begin
            // no request in the first cycle out of reset
            started       <= 1'b1;
            req_hold      <= busy;
            data_expected <= accept;
            if (i_redirect_valid) begin
                // a pair accepted now belongs to the old stream
                drop <= accept;
                if (busy) begin
                    pend_valid <= 1'b1;
                end else begin
                    pend_valid <= 1'b0;
                    fetch_pc   <= i_redirect_pc;
                    halted     <= 1'b0;
                end
            end else if (accept) begin
                // open request done, the held target takes over
                drop       <= pend_valid;
                pend_valid <= 1'b0;
                fetch_pc   <= pend_valid ? pend_pc : fetch_pc + 32'd8;
            end else begin
                drop <= 1'b0;
                if (exc_push) begin
                    halted <= 1'b1;
                end
            end
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        // latest redirect wins while still waiting
        if (i_redirect_valid && busy) begin
            pend_pc <= i_redirect_pc;
        end
        // pc of the pair due next cycle
        if (accept) begin
            rsp_pc <= fetch_pc;
        end
    end

endmodule

/* fetch_queue.sv */
module fetch_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic        clk,
    input  logic        reset,
    fetch_pair_if.sink  pair,
    inst_slot_if.source slot
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    core_pkg::inst_entry_t mem [QUEUE_DEPTH];
    core_pkg::inst_entry_t entry_lo;
    core_pkg::inst_entry_t entry_hi;

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] wr_ptr_nxt;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] push_n;
    logic [CNT_W-1:0] pop_n;

    // second slot of a pair, wraps with the pointer
    assign wr_ptr_nxt = wr_ptr + 1'b1;

    always_comb begin
        // first entry at push_pc
        // exc entry gets a zero instruction
        entry_lo.pc   = pair.push_pc;
        entry_lo.inst = pair.push_exc ? '0 : pair.push_data[31:0];
        entry_lo.exc  = pair.push_exc;
        // second entry at pc + 4, only for a normal pair
        entry_hi.pc   = pair.push_pc + 32'd4;
        entry_hi.inst = pair.push_data[63:32];
        entry_hi.exc  = 1'b0;
    end

    // entries written this cycle
    always_comb begin
        if (!pair.push) begin
            push_n = '0;
        end else if (pair.push_exc) begin
            push_n = CNT_W'(1);
        end else begin
            push_n = CNT_W'(2);
        end
    end

    assign pop_n = CNT_W'(slot.pop);

    always_ff @(posedge clk) begin
        if (pair.push) begin
            mem[wr_ptr] <= entry_lo;
            if (!pair.push_exc) begin
                mem[wr_ptr_nxt] <= entry_hi;
            end
        end
    end

    always_ff @(posedge clk) begin
        // flush drops everything, including a pop this cycle
        if (reset || pair.flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + push_n[PTR_W-1:0];
            if (slot.pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + push_n - pop_n;
        end
    end

    // registered, so the sequencer keeps its margin
    assign pair.free_slots = CNT_W'(QUEUE_DEPTH) - count;

    assign slot.head_valid = count != '0;
    assign slot.head       = mem[rd_ptr];

endmodule

/* inst_predecode.sv */
module inst_predecode (
    inst_slot_if.sink             slot,
    input  logic                  i_inst_ready,
    output logic                  o_inst_valid,
    output core_pkg::word_t       o_inst_pc,
    output core_pkg::word_t       o_inst,
    output logic                  o_inst_exc,
    output core_pkg::inst_class_e o_inst_class
);

    core_pkg::opcode_t opcode;
    core_pkg::funct_t  funct;

    assign opcode = slot.head.inst[31:26];
    assign funct  = slot.head.inst[5:0];

    // head goes straight out
    // it stays put until taken
    assign o_inst_valid = slot.head_valid;
    assign o_inst_pc    = slot.head.pc;
    assign o_inst       = slot.head.inst;
    assign o_inst_exc   = slot.head.exc;

    // consumed on valid and ready
    assign slot.pop = slot.head_valid & i_inst_ready;

    always_comb begin
        o_inst_class = core_pkg::class_none;
        // exc entry is never a branch
        if (!slot.head.exc) begin
            case (opcode)
                core_pkg::OPC_BEQ,
                core_pkg::OPC_BNE,
                core_pkg::OPC_BLEZ,
                core_pkg::OPC_BGTZ: begin
                    o_inst_class = core_pkg::class_branch;
                end
                core_pkg::OPC_J,
                core_pkg::OPC_JAL: begin
                    o_inst_class = core_pkg::class_jump;
                end
                core_pkg::OPC_SPECIAL: begin
                    // jr and jalr, target from a register
                    if (funct == core_pkg::FUNCT_JR || funct == core_pkg::FUNCT_JALR) begin
                        o_inst_class = core_pkg::class_jump_reg;
                    end
                end
                default: begin
                    o_inst_class = core_pkg::class_none;
                end
            endcase
        end
    end

endmodule

/* fetch_frontend.sv */
module fetch_frontend #(
    parameter core_pkg::word_t RESET_PC = 32'hbfc0_0000,
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  reset,

    // instruction bus
    output logic                  o_ireq_valid,
    output core_pkg::word_t       o_ireq_addr,
    input  logic                  i_iresp_addr_ok,
    input  core_pkg::pair_t       i_iresp_data,

    // redirect, one cycle
    input  logic                  i_redirect_valid,
    input  core_pkg::word_t       i_redirect_pc,

    // one instruction per cycle
    output logic                  o_inst_valid,
    output core_pkg::word_t       o_inst_pc,
    output core_pkg::word_t       o_inst,
    output logic                  o_inst_exc,
    output core_pkg::inst_class_e o_inst_class,
    input  logic                  i_inst_ready
);

    // sequencer to queue
    fetch_pair_if #(.QUEUE_DEPTH(QUEUE_DEPTH)) pair_bus ();

    // queue head to predecode
    inst_slot_if slot_bus ();

    pc_sequencer #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_pc_sequencer (
        .clk              (clk),
        .reset            (reset),
        .i_redirect_valid (i_redirect_valid),
        .i_redirect_pc    (i_redirect_pc),
        .i_iresp_addr_ok  (i_iresp_addr_ok),
        .i_iresp_data     (i_iresp_data),
        .o_ireq_valid     (o_ireq_valid),
        .o_ireq_addr      (o_ireq_addr),
        .pair             (pair_bus.source)
    );

    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_fetch_queue (
        .clk   (clk),
        .reset (reset),
        .pair  (pair_bus.sink),
        .slot  (slot_bus.source)
    );

    inst_predecode u_inst_predecode (
        .slot         (slot_bus.sink),
        .i_inst_ready (i_inst_ready),
        .o_inst_valid (o_inst_valid),
        .o_inst_pc    (o_inst_pc),
        .o_inst       (o_inst),
        .o_inst_exc   (o_inst_exc),
        .o_inst_class (o_inst_class)
    );

endmodule

/* fetch_frontend_assert.sv */
module fetch_queue_assert #(
    parameter int QUEUE_DEPTH = 8
) (
    input logic                         clk,
    input logic                         reset,
    input logic [$clog2(QUEUE_DEPTH):0] count,
    input logic                         push,
    input logic                         push_exc,
    input logic                         pop,
    input logic                         flush
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1;

    // entries pushed and not yet popped
    // tracked from the handshakes, apart from the queue counter
    logic [CNT_W-1:0] occupancy;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            occupancy <= '0;
        end else if (push && !push_exc) begin
            occupancy <= occupancy + CNT_W'(2) - CNT_W'(pop);
        end else if (push) begin
            occupancy <= occupancy + CNT_W'(1) - CNT_W'(pop);
        end else begin
            occupancy <= occupancy - CNT_W'(pop);
        end
    end

    // occupancy bounded by the buffer size
    a_count_max: assert property (@(posedge clk) disable iff (reset)
        count <= QUEUE_DEPTH)
        else $error("fetch queue count %0d above depth", count);

    // consumer only takes a valid head
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> occupancy != '0)
        else $error("pop from an empty fetch queue");

    // sequencer never pushes into a flush
    a_no_push_flush: assert property (@(posedge clk) disable iff (reset)
        !(push && flush))
        else $error("push and flush in the same cycle");

endmodule

bind fetch_queue fetch_queue_assert #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
) u_queue_assert (
    .clk      (clk),
    .reset    (reset),
    .count    (count),
    .push     (pair.push),
    .push_exc (pair.push_exc),
    .pop      (slot.pop),
    .flush    (pair.flush)
);

/* tb_fetch_frontend.sv */
module tb_fetch_frontend;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS = 7;
    // odd multiplier for the address hash
    localparam logic [31:0] HASH_MUL = 32'h9e37_79b1;

    // one scenario step
    typedef struct packed {
        int          wait_cyc;
        logic        redir;
        logic [31:0] target;
        logic        ok_low;
        logic [15:0] ready_pat;
        int          count;
    } row_t;

    // wait, redirect, target, addr_ok low, ready duty, instructions to check
    row_t rows [NUM_ROWS] = '{
        '{0,  1'b0, 32'h0000_0000, 1'b0, 16'hffff, 24},
        '{0,  1'b0, 32'h0000_0000, 1'b0, 16'h000f, 20},
        '{5,  1'b1, 32'h0000_1000, 1'b0, 16'hffff, 16},
        '{12, 1'b1, 32'h0040_0100, 1'b1, 16'h5555, 16},
        '{4,  1'b1, 32'h0000_2002, 1'b0, 16'hffff, 1},
        '{20, 1'b1, 32'h0000_3000, 1'b0, 16'hf0f0, 16},
        '{2,  1'b1, 32'h0000_1008, 1'b0, 16'h3fff, 12}
    };

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  o_ireq_valid;
    core_pkg::word_t       o_ireq_addr;
    logic                  i_iresp_addr_ok;
    core_pkg::pair_t       i_iresp_data;
    logic                  i_redirect_valid;
    core_pkg::word_t       i_redirect_pc;
    logic                  o_inst_valid;
    core_pkg::word_t       o_inst_pc;
    core_pkg::word_t       o_inst;
    logic                  o_inst_exc;
    core_pkg::inst_class_e o_inst_class;
    logic                  i_inst_ready;

    integer seed = 54155;
    int errors = 0;
    int total_checks = 0;
    int row_checks = 0;
    int skipped = 0;
    int cycles = 0;
    int ok_block = 0;
    logic [15:0] ready_pat = 16'hffff;
    // scoreboard state
    logic [31:0] exp_pc = 32'hbfc0_0000;
    logic synced = 1'b1;
    logic halted_exp = 1'b0;
    // bus request seen before the edge
    logic acc_q = 1'b0;
    logic [31:0] acc_addr = '0;
    // request left waiting on addr_ok
    logic req_wait = 1'b0;
    // output seen one cycle earlier
    logic prev_stall = 1'b0;
    logic [31:0] prev_pc = '0;
    logic [31:0] prev_inst = '0;

    fetch_frontend #(
        .RESET_PC    (32'hbfc0_0000),
        .QUEUE_DEPTH (8)
    ) uut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    function automatic logic [31:0] hash_word(input logic [31:0] a);
        return (a * HASH_MUL) ^ (a >> 5) ^ 32'h5a5a_0f0f;
    endfunction

    // class-test words on top of the hash
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        case (a)
            32'h0000_1000: return 32'h1085_0004;  // beq
            32'h0000_1004: return 32'h0800_0040;  // j
            32'h0000_1008: return 32'h03e0_0008;  // jr
            32'h0000_100c: return 32'h0040_f809;  // jalr
            32'h0000_1010: return 32'h1c40_0003;  // bgtz
            32'h0000_1014: return 32'h0043_2021;  // addu, no class
            32'h0000_1018: return 32'h0c00_0100;  // jal
            default:       return hash_word(a);
        endcase
    endfunction

    function automatic core_pkg::inst_class_e class_of(input logic [31:0] w);
        case (w[31:26])
            6'h04, 6'h05, 6'h06, 6'h07: return core_pkg::class_branch;
            6'h02, 6'h03:               return core_pkg::class_jump;
            6'h00: begin
                if (w[5:0] == 6'h08 || w[5:0] == 6'h09) begin
                    return core_pkg::class_jump_reg;
                end
                return core_pkg::class_none;
            end
            default:                    return core_pkg::class_none;
        endcase
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        errors++;
        $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
    endtask

    task automatic check_output();
        core_pkg::inst_class_e exp_class;
        logic [31:0] exp_inst;
        if (halted_exp) begin
            errors++;
            $display("%0t instruction at pc %h came out after a misaligned exception", $time,
                     o_inst_pc);
        end else if (!synced && o_inst_pc != exp_pc) begin
            skipped++;
        end else begin
            synced = 1'b1;
            // exc entry for a misaligned target
            exp_inst  = (exp_pc[1:0] != 2'b00) ? 32'h0 : mem_word(exp_pc);
            exp_class = (exp_pc[1:0] != 2'b00) ? core_pkg::class_none : class_of(exp_inst);
            if (o_inst_pc !== exp_pc) report_value("o_inst_pc", exp_pc, o_inst_pc);
            if (o_inst !== exp_inst) report_value("o_inst", exp_inst, o_inst);
            if (o_inst_exc !== (exp_pc[1:0] != 2'b00)) begin
                report_value("o_inst_exc", 32'(exp_pc[1:0] != 2'b00), 32'(o_inst_exc));
            end
            if (o_inst_class !== exp_class) begin
                report_value("o_inst_class", 32'(exp_class), 32'(o_inst_class));
            end
            halted_exp = exp_pc[1:0] != 2'b00;
            exp_pc = exp_pc + 32'd4;
            row_checks++;
            total_checks++;
        end
    endtask

    // memory model and handshake inputs
    always @(negedge clk) begin
        // an open request keeps its address until addr_ok
        if (!reset && req_wait && (!o_ireq_valid || o_ireq_addr !== acc_addr)) begin
            errors++;
            $display("%0t bus request at %h dropped or moved before addr_ok", $time,
                     acc_addr);
        end
        req_wait = o_ireq_valid && !i_iresp_addr_ok;
        acc_q    = o_ireq_valid && i_iresp_addr_ok;
        acc_addr = o_ireq_addr;
    end

    always @(posedge clk) begin
        #1;
        if (acc_q) i_iresp_data = {mem_word(acc_addr + 32'd4), mem_word(acc_addr)};
        if (ok_block != 0) begin
            i_iresp_addr_ok = 1'b0;
            ok_block--;
        end else begin
            i_iresp_addr_ok = ($random(seed) & 3) != 0;
        end
        i_inst_ready = ready_pat[cycles % 16];
    end

    // scoreboard and hold check
    always @(negedge clk) begin
        if (!reset) begin
            if (prev_stall && !i_redirect_valid && (!o_inst_valid || o_inst_pc !== prev_pc
                                                    || o_inst !== prev_inst)) begin
                errors++;
                $display("%0t output changed while ready was low, pc %h", $time, prev_pc);
            end
            prev_stall = o_inst_valid && !i_inst_ready && !i_redirect_valid;
            prev_pc    = o_inst_pc;
            prev_inst  = o_inst;
            if (i_redirect_valid) begin
                // consumed entry here is flushed
                exp_pc     = i_redirect_pc;
                synced     = 1'b0;
                halted_exp = 1'b0;
                row_checks = 0;
            end else if (o_inst_valid && i_inst_ready) begin
                check_output();
            end
        end
    end

    task automatic apply_row(input int r);
        int w;
        @(posedge clk);
        ready_pat = rows[r].ready_pat;
        if (!rows[r].redir) row_checks = 0;
        for (w = 0; w < rows[r].wait_cyc; w++) begin
            // addr_ok low from here through the redirect
            // queue drains, so the request is open and waiting
            if (rows[r].ok_low && w == 0) ok_block = rows[r].wait_cyc + 2;
            @(posedge clk);
        end
        if (rows[r].redir) begin
            #1;
            i_redirect_valid = 1'b1;
            i_redirect_pc    = rows[r].target;
            @(posedge clk);
            #1;
            i_redirect_valid = 1'b0;
        end
        while (row_checks < rows[r].count) @(posedge clk);
    endtask

    initial begin
        int limit;
        limit = 0;
        for (int r = 0; r < NUM_ROWS; r++) limit += rows[r].count;
        limit = 20 * limit + 200;
        while (cycles < limit) @(posedge clk);
        $display("run timed out after %0d cycles with %0d checks done", cycles, total_checks);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        reset            = 1'b1;
        i_iresp_addr_ok  = 1'b0;
        i_iresp_data     = '0;
        i_redirect_valid = 1'b0;
        i_redirect_pc    = '0;
        i_inst_ready     = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(r);
            $display("row %0d done at %0t: %0d checked, %0d skipped, %0d errors so far",
                     r, $time, row_checks, skipped, errors);
        end
        $display("checks %0d, skipped %0d, errors %0d", total_checks, skipped, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
core_pkg.sv
fetch_pair_if.sv
inst_slot_if.sv
pc_sequencer.sv
fetch_queue.sv
inst_predecode.sv
fetch_frontend.sv
fetch_frontend_assert.sv
tb_fetch_frontend.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module tb_fetch_frontend \
    -o sim_fetch_frontend

./obj_dir/sim_fetch_frontend 2>&1 | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
else
    exit 1
fi
